// ==== list.f ====
src/panel_pkg.sv
src/i2c_adc_reader.sv
src/key_panel.sv
src/display_formatter.sv
src/seg_scan.sv
src/adc_panel_top.sv
tb/i2c_adc_model.sv
tb/tb_adc_panel.sv

// ==== Makefile ====
# Verilator build and run for the ADC panel testbench

VERILATOR  ?= verilator
TOP        ?= tb_adc_panel
RTL_TOP    ?= adc_panel_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_adc_panel.sv ====
/*
 * ADC panel testbench
 * drives keys and a converter model, decodes the display and checks it
 */
`timescale 1ns/10ps
`default_nettype none

module tb_adc_panel
	import panel_pkg::*;
();

	logic        sys_clk;
	logic        sys_rst_n;
	logic [2:0]  key_in;
	logic [7:0]  seg_number;
	logic [7:0]  seg_choice;
	logic        scl;
	logic        sda_pull_low;
	logic        slave_low;
	logic        sda_line;
	logic [31:0] chan_bytes;
	logic        ack_on;
	logic [7:0]  model_ctrl;
	logic [31:0] stop_count;

	logic [31:0] lfsr;
	logic [4:0]  picture [8];
	logic [7:0]  last_choice;
	int          scan_steps;

	// expected formatter state
	logic [1:0]  exp_chan;
	logic        exp_hold;
	logic        exp_err;
	logic        exp_hex;
	logic        exp_have;
	logic [7:0]  exp_val;

	logic [7:0]  fixed_vals [6] = '{8'd0, 8'd9, 8'd10, 8'd99, 8'd100, 8'd255};
	logic [7:0]  rnd;

	// open-drain line with pull-up
	assign sda_line = ~(sda_pull_low | slave_low);

	adc_panel_top dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.scl          (scl),
		.sda_pull_low (sda_pull_low),
		.sda_in       (sda_line)
	);

	i2c_adc_model slave0 (
		.scl        (scl),
		.sda        (sda_line),
		.chan_bytes (chan_bytes),
		.ack_on     (ack_on),
		.sda_low    (slave_low),
		.ctrl_byte  (model_ctrl),
		.stop_count (stop_count)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s >> 1;
		if (s[0])
			lfsr_next = lfsr_next ^ 32'h80200003;
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = 8'd0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// segment pattern back to glyph, active high gfedcba
	function automatic logic [4:0] glyph_of(input logic [7:0] seg);
		// a lit decimal point matches no glyph
		if (!seg[7]) begin
			glyph_of = 5'h1f;
		end else begin
			case (~seg[6:0])
			7'h3f: glyph_of = 5'd0;
			7'h06: glyph_of = 5'd1;
			7'h5b: glyph_of = 5'd2;
			7'h4f: glyph_of = 5'd3;
			7'h66: glyph_of = 5'd4;
			7'h6d: glyph_of = 5'd5;
			7'h7d: glyph_of = 5'd6;
			7'h07: glyph_of = 5'd7;
			7'h7f: glyph_of = 5'd8;
			7'h6f: glyph_of = 5'd9;
			7'h77: glyph_of = 5'd10;
			7'h7c: glyph_of = 5'd11;
			7'h39: glyph_of = 5'd12;
			7'h5e: glyph_of = 5'd13;
			7'h79: glyph_of = 5'd14;
			7'h71: glyph_of = 5'd15;
			7'h76: glyph_of = GLYPH_H;
			7'h40: glyph_of = GLYPH_DASH;
			7'h00: glyph_of = GLYPH_BLANK;
			default: glyph_of = 5'h1f;
			endcase
		end
	endfunction

	// E and hex digit E light the same segments
	function automatic logic [4:0] face_of(input logic [4:0] g);
		face_of = (g == GLYPH_E) ? 5'd14 : g;
	endfunction

	function automatic logic [4:0] expected_glyph(input int idx);
		int v;
		int h;
		int t;
		v = int'(exp_val);
		h = v / 100;
		t = (v / 10) % 10;
		case (idx)
		7: expected_glyph = {3'b000, exp_chan};
		6: expected_glyph = exp_hold ? GLYPH_H : GLYPH_BLANK;
		5: expected_glyph = exp_err ? GLYPH_E : GLYPH_BLANK;
		4, 3: expected_glyph = GLYPH_BLANK;
		2: expected_glyph = (!exp_have || exp_hex) ? GLYPH_DASH :
			(h != 0) ? 5'(h) : GLYPH_BLANK;
		1: expected_glyph = !exp_have ? GLYPH_DASH : exp_hex ? {1'b0, exp_val[7:4]} :
			(h != 0 || t != 0) ? 5'(t) : GLYPH_BLANK;
		default: expected_glyph = !exp_have ? GLYPH_DASH : exp_hex ? {1'b0, exp_val[3:0]} :
			5'(v % 10);
		endcase
	endfunction

	function automatic logic [7:0] byte_of(input logic [1:0] ch);
		case (ch)
		2'd0: byte_of = chan_bytes[7:0];
		2'd1: byte_of = chan_bytes[15:8];
		2'd2: byte_of = chan_bytes[23:16];
		default: byte_of = chan_bytes[31:24];
		endcase
	endfunction

	// picture of the display, one digit per select
	always @(negedge sys_clk) begin
		if (!sys_rst_n) begin
			scan_steps <= 0;
			last_choice <= 8'hff;
			for (int i = 0; i < 8; i++)
				picture[3'(i)] <= 5'h1f;
		end else begin
			if (seg_choice != last_choice)
				scan_steps <= scan_steps + 1;
			last_choice <= seg_choice;
			for (int i = 0; i < 8; i++)
				if (seg_choice == ~(8'd1 << i))
					picture[3'(i)] <= glyph_of(seg_number);
		end
	end

	task automatic stop_with_failure();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("ERR %0t %s: got %0h, expected %0h", $time, name, got, want);
		stop_with_failure();
	endtask

	task automatic load_byte(input logic [1:0] ch, input logic [7:0] v);
		@(negedge sys_clk);
		case (ch)
		2'd0: chan_bytes[7:0] = v;
		2'd1: chan_bytes[15:8] = v;
		2'd2: chan_bytes[23:16] = v;
		default: chan_bytes[31:24] = v;
		endcase
	endtask

	task automatic press_key(input int k);
		@(negedge sys_clk);
		key_in[2'(k)] = 1'b0;
		repeat (DEBOUNCE_CYCLES + 256) @(negedge sys_clk);
		key_in[2'(k)] = 1'b1;
		repeat (DEBOUNCE_CYCLES + 256) @(negedge sys_clk);
	endtask

	task automatic wait_stops(input int n);
		logic [31:0] target;
		int cycles;
		target = stop_count + 32'(n);
		cycles = 0;
		while (stop_count < target) begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > (n + 1) * 12000) begin
				$display("timeout: the I2C reader finished no transaction in time");
				stop_with_failure();
			end
		end
	endtask

	task automatic wait_scan_steps(input int n);
		int target;
		int cycles;
		target = scan_steps + n;
		cycles = 0;
		while (scan_steps < target) begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > (n + 1) * SCAN_CYCLES + 100) begin
				$display("timeout: the digit selects stopped moving");
				stop_with_failure();
			end
		end
	endtask

	task automatic check_display(input string what);
		logic [4:0] want;
		for (int i = 0; i < 8; i++) begin
			want = face_of(expected_glyph(i));
			assert (picture[3'(i)] == want)
			else report_mismatch($sformatf("display digit %0d (%s)", i, what),
				32'(picture[3'(i)]), 32'(want));
		end
	endtask

	// two stops make sure a whole read saw the current settings
	task automatic settle_and_check(input string what);
		wait_stops(2);
		if (ack_on) begin
			exp_err = 1'b0;
			if (!exp_hold) begin
				exp_val = byte_of(exp_chan);
				exp_have = 1'b1;
			end
		end else begin
			exp_err = 1'b1;
		end
		wait_scan_steps(10);
		check_display(what);
	endtask

	initial begin
		key_in = 3'b111;
		sys_rst_n = 1'b0;
		ack_on = 1'b1;
		chan_bytes = 32'd0;
		lfsr = 32'hfb;
		rnd = 8'd0;
		exp_chan = 2'd0;
		exp_hold = 1'b0;
		exp_err = 1'b0;
		exp_hex = 1'b0;
		exp_have = 1'b0;
		exp_val = 8'd0;
		for (int ch = 0; ch < 4; ch++) begin
			random_byte(rnd);
			chan_bytes = {rnd, chan_bytes[31:8]};
		end
		repeat (8) @(negedge sys_clk);
		assert (seg_choice == 8'hff) else report_mismatch("seg_choice", 32'(seg_choice), 32'hff);
		sys_rst_n = 1'b1;

		// idle bus and dark display right after reset
		repeat (200) begin
			@(negedge sys_clk);
			assert (seg_choice == 8'hff)
			else report_mismatch("seg_choice", 32'(seg_choice), 32'hff);
			assert (scl == 1'b1) else report_mismatch("scl", 32'(scl), 32'd1);
			assert (sda_pull_low == 1'b0)
			else report_mismatch("sda_pull_low", 32'(sda_pull_low), 32'd0);
		end
		// one pass over all digits ends before the first read
		wait_scan_steps(8);
		check_display("after reset");

		for (int i = 0; i < 10; i++) begin
			if (i < 6) begin
				rnd = fixed_vals[3'(i)];
			end else begin
				random_byte(rnd);
			end
			load_byte(2'd0, rnd);
			settle_and_check("decimal");
		end

		load_byte(2'd0, 8'hc7);
		settle_and_check("decimal before hex");
		press_key(0);
		exp_hex = 1'b1;
		settle_and_check("hex");
		press_key(0);
		exp_hex = 1'b0;
		settle_and_check("back to decimal");

		press_key(1);
		exp_hold = 1'b1;
		settle_and_check("hold on");
		random_byte(rnd);
		load_byte(2'd0, rnd ^ 8'h5a);
		settle_and_check("held value");
		press_key(1);
		exp_hold = 1'b0;
		settle_and_check("hold off");

		for (int k = 0; k < 4; k++) begin
			press_key(2);
			exp_chan = exp_chan + 2'd1;
			settle_and_check("channel step");
			assert (model_ctrl == {6'd0, exp_chan})
			else report_mismatch("model control byte", 32'(model_ctrl), 32'(exp_chan));
		end

		@(negedge sys_clk);
		ack_on = 1'b0;
		random_byte(rnd);
		load_byte(exp_chan, rnd);
		settle_and_check("refused address");
		@(negedge sys_clk);
		ack_on = 1'b1;
		settle_and_check("recovered read");

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/i2c_adc_model.sv ====
/*
 * I2C converter slave model
 * acks its address, records the control byte, returns one byte per channel
 */
`timescale 1ns/10ps
`default_nettype none

module i2c_adc_model
	import panel_pkg::*;
(
	input  logic        scl,
	input  logic        sda,
	input  logic [31:0] chan_bytes,
	input  logic        ack_on,
	output logic        sda_low,
	output logic [7:0]  ctrl_byte,
	output logic [31:0] stop_count
);

	logic       scl_q;
	logic       sda_q;
	logic       active;
	logic       in_addr;
	logic       addr_ok;
	logic       read_mode;
	logic       sending;
	logic [7:0] rx_byte;
	logic [7:0] tx_byte;
	int         bit_i;

	initial begin
		scl_q = 1'b1;
		sda_q = 1'b1;
		active = 1'b0;
		in_addr = 1'b0;
		addr_ok = 1'b0;
		read_mode = 1'b0;
		sending = 1'b0;
		rx_byte = 8'd0;
		tx_byte = 8'd0;
		bit_i = 0;
		sda_low = 1'b0;
		ctrl_byte = 8'd0;
		stop_count = 32'd0;
		forever begin
			@(scl or sda);
			if (scl_q && scl && sda_q && !sda) begin
				// start or repeated start
				active = 1'b1;
				in_addr = 1'b1;
				sending = 1'b0;
				bit_i = 0;
				sda_low = 1'b0;
			end else if (scl_q && scl && !sda_q && sda) begin
				active = 1'b0;
				sending = 1'b0;
				sda_low = 1'b0;
				stop_count = stop_count + 32'd1;
			end else if (active && !scl_q && scl) begin
				if (bit_i < 8)
					rx_byte = {rx_byte[6:0], sda};
				bit_i = bit_i + 1;
			end else if (active && scl_q && !scl) begin
				if (bit_i == 8) begin
					// ack slot follows
					if (sending) begin
						sda_low = 1'b0;
					end else if (in_addr) begin
						addr_ok = (rx_byte[7:1] == ADC_DEV_ADDR) && ack_on;
						read_mode = rx_byte[0];
						sda_low = addr_ok;
					end else if (addr_ok) begin
						ctrl_byte = rx_byte;
						sda_low = 1'b1;
					end
				end else if (bit_i == 9) begin
					bit_i = 0;
					sda_low = 1'b0;
					if (sending) begin
						// master answered the data byte, read is over
						sending = 1'b0;
					end else if (in_addr) begin
						in_addr = 1'b0;
						if (addr_ok && read_mode) begin
							sending = 1'b1;
							case (ctrl_byte[1:0])
							2'd0: tx_byte = chan_bytes[7:0];
							2'd1: tx_byte = chan_bytes[15:8];
							2'd2: tx_byte = chan_bytes[23:16];
							default: tx_byte = chan_bytes[31:24];
							endcase
							sda_low = !tx_byte[7];
						end
					end
				end else if (sending && bit_i > 0) begin
					tx_byte = {tx_byte[6:0], 1'b0};
					sda_low = !tx_byte[7];
				end
			end
			scl_q = scl;
			sda_q = sda;
		end
	end

endmodule

`default_nettype wire

// ==== src/adc_panel_top.sv ====
/*
 * ADC display panel top
 * I2C reader, key panel, formatter and display scanner
 */
`timescale 1ns/10ps
`default_nettype none

module adc_panel_top
	import panel_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [2:0] key_in,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice,
	output logic       scl,
	output logic       sda_pull_low,
	input  logic       sda_in
);

	logic [7:0]           sample;
	logic                 sample_valid;
	logic                 nack_error;
	logic                 hex_mode;
	logic                 hold;
	logic [CHAN_W-1:0]    channel;
	logic [8*GLYPH_W-1:0] digits;

	i2c_adc_reader u_reader (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.channel      (channel),
		.sample       (sample),
		.sample_valid (sample_valid),
		.nack_error   (nack_error),
		.scl          (scl),
		.sda_pull_low (sda_pull_low),
		.sda_in       (sda_in)
	);

	key_panel u_keys (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.hex_mode  (hex_mode),
		.hold      (hold),
		.channel   (channel)
	);

	display_formatter u_format (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.nack_error   (nack_error),
		.hex_mode     (hex_mode),
		.hold         (hold),
		.channel      (channel),
		.digits       (digits)
	);

	seg_scan u_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.digits     (digits),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

`default_nettype wire

// ==== src/seg_scan.sv ====
/*
 * Seven-segment scanner
 * lights one digit at a time; seg_number is {dp, g, f, e, d, c, b, a}, active low
 */
`timescale 1ns/10ps
`default_nettype none

module seg_scan
	import panel_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [8*GLYPH_W-1:0] digits,
	output logic [7:0]           seg_number,
	output logic [7:0]           seg_choice
);

	logic [SCAN_W-1:0]  dwell_cnt;
	logic               step;
	logic               scan_on;
	logic [2:0]         cur_idx;
	logic [GLYPH_W-1:0] glyph;
	logic [6:0]         seg_on;

	assign step = (dwell_cnt == SCAN_W'(SCAN_CYCLES - 1));
	assign glyph = digits[cur_idx * GLYPH_W +: GLYPH_W];

	// active high gfedcba
	always_comb begin
		case (glyph)
		5'd0:       seg_on = 7'h3f;
		5'd1:       seg_on = 7'h06;
		5'd2:       seg_on = 7'h5b;
		5'd3:       seg_on = 7'h4f;
		5'd4:       seg_on = 7'h66;
		5'd5:       seg_on = 7'h6d;
		5'd6:       seg_on = 7'h7d;
		5'd7:       seg_on = 7'h07;
		5'd8:       seg_on = 7'h7f;
		5'd9:       seg_on = 7'h6f;
		5'd10:      seg_on = 7'h77;
		5'd11:      seg_on = 7'h7c;
		5'd12:      seg_on = 7'h39;
		5'd13:      seg_on = 7'h5e;
		5'd14:      seg_on = 7'h79;
		5'd15:      seg_on = 7'h71;
		GLYPH_E:    seg_on = 7'h79;
		GLYPH_H:    seg_on = 7'h76;
		GLYPH_DASH: seg_on = 7'h40;
		default:    seg_on = 7'h00;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dwell_cnt <= '0;
			scan_on <= 1'b0;
			cur_idx <= 3'd0;
		end else if (step) begin
			dwell_cnt <= '0;
			scan_on <= 1'b1;
			// the first step lights digit 0
			if (scan_on)
				cur_idx <= cur_idx + 3'd1;
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_choice <= 8'hff;
			seg_number <= 8'hff;
		end else if (scan_on) begin
			seg_choice <= ~(8'd1 << cur_idx);
			seg_number <= {1'b1, ~seg_on};
		end
	end

	one_digit_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$past(scan_on) |-> $onehot(~seg_choice));

endmodule

`default_nettype wire

// ==== src/display_formatter.sv ====
/*
 * Display formatter
 * builds eight glyph codes from the latest sample, error flag and settings
 */
`timescale 1ns/10ps
`default_nettype none

module display_formatter
	import panel_pkg::*;
(
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic [7:0]             sample,
	input  logic                   sample_valid,
	input  logic                   nack_error,
	input  logic                   hex_mode,
	input  logic                   hold,
	input  logic [CHAN_W-1:0]      channel,
	output logic [8*GLYPH_W-1:0]   digits
);

	logic [7:0]         value;
	logic               have_value;
	logic               err_flag;
	logic [7:0]         value_n;
	logic               have_n;
	logic               err_n;
	logic [3:0]         hund;
	logic [3:0]         tens;
	logic [3:0]         ones;
	logic [GLYPH_W-1:0] d2;
	logic [GLYPH_W-1:0] d1;
	logic [GLYPH_W-1:0] d0;

	// a held display still takes the error clear from a good read
	always_comb begin
		value_n = value;
		have_n = have_value;
		err_n = err_flag;
		if (nack_error)
			err_n = 1'b1;
		if (sample_valid) begin
			err_n = 1'b0;
			if (!hold) begin
				value_n = sample;
				have_n = 1'b1;
			end
		end
	end

	assign hund = 4'(value_n / 8'd100);
	assign tens = 4'((value_n / 8'd10) % 8'd10);
	assign ones = 4'(value_n % 8'd10);

	always_comb begin
		if (!have_n) begin
			d2 = GLYPH_DASH;
			d1 = GLYPH_DASH;
			d0 = GLYPH_DASH;
		end else if (hex_mode) begin
			d2 = GLYPH_DASH;
			d1 = GLYPH_W'(value_n[7:4]);
			d0 = GLYPH_W'(value_n[3:0]);
		end else begin
			// blank leading zeros, keep the units digit
			d2 = (hund != 4'd0) ? GLYPH_W'(hund) : GLYPH_BLANK;
			d1 = (hund != 4'd0 || tens != 4'd0) ? GLYPH_W'(tens) : GLYPH_BLANK;
			d0 = GLYPH_W'(ones);
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			value <= 8'd0;
			have_value <= 1'b0;
			err_flag <= 1'b0;
			digits <= {GLYPH_W'(0), GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK,
				GLYPH_DASH, GLYPH_DASH, GLYPH_DASH};
		end else begin
			value <= value_n;
			have_value <= have_n;
			err_flag <= err_n;
			digits <= {GLYPH_W'(channel), hold ? GLYPH_H : GLYPH_BLANK,
				err_n ? GLYPH_E : GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, d2, d1, d0};
		end
	end

endmodule

`default_nettype wire

// ==== src/key_panel.sv ====
/*
 * Key panel
 * debounces three buttons and keeps the mode, hold and channel settings
 */
`timescale 1ns/10ps
`default_nettype none

module key_panel
	import panel_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic [2:0]        key_in,
	output logic              hex_mode,
	output logic              hold,
	output logic [CHAN_W-1:0] channel
);

	logic [2:0]            key_meta;
	logic [2:0]            key_sync;
	logic [2:0]            key_state;
	logic [2:0]            press;
	logic [DEBOUNCE_W-1:0] stable_cnt [3];

	// keys idle high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= 3'b111;
			key_sync <= 3'b111;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
		end
	end

	// accept a new level after it held for the whole debounce window
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_state <= 3'b000;
			press <= 3'b000;
			for (int i = 0; i < 3; i++)
				stable_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				press[i] <= 1'b0;
				if (key_state[i] == !key_sync[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
					stable_cnt[i] <= '0;
					key_state[i] <= !key_sync[i];
					press[i] <= !key_sync[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			hex_mode <= 1'b0;
			hold <= 1'b0;
			channel <= '0;
		end else begin
			if (press[0])
				hex_mode <= !hex_mode;
			if (press[1])
				hold <= !hold;
			// channel wraps 3 -> 0
			if (press[2])
				channel <= channel + CHAN_W'(1);
		end
	end

	chan_step_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$changed(channel) |-> (channel == $past(channel) + CHAN_W'(1)));

endmodule

`default_nettype wire

// ==== src/i2c_adc_reader.sv ====
/*
 * I2C converter reader
 * polls the ADC forever: write control byte, repeated start, read one byte
 */
`timescale 1ns/10ps
`default_nettype none

module i2c_adc_reader
	import panel_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic [CHAN_W-1:0] channel,
	output logic [7:0]        sample,
	output logic              sample_valid,
	output logic              nack_error,
	output logic              scl,
	output logic              sda_pull_low,
	input  logic              sda_in
);

	logic [QUARTER_W-1:0] q_cnt;
	logic                 tick;
	logic [1:0]           quarter;
	logic [2:0]           phase;
	logic [1:0]           byte_idx;
	logic [3:0]           bit_cnt;
	logic [7:0]           shreg;
	logic [CHAN_W-1:0]    chan_lat;
	logic                 sda_bit;
	logic                 ack_fail;
	logic [1:0]           sda_sync;
	logic                 tx_byte;

	assign tick = (q_cnt == QUARTER_W'(I2C_QUARTER - 1));
	// bytes 0..2 go out, byte 3 comes in
	assign tx_byte = (byte_idx != 2'd3);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			q_cnt <= '0;
		else if (tick)
			q_cnt <= '0;
		else
			q_cnt <= q_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			sda_sync <= 2'b11;
		else
			sda_sync <= {sda_sync[0], sda_in};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			quarter <= 2'd0;
			phase <= PH_IDLE;
			byte_idx <= 2'd0;
			bit_cnt <= 4'd0;
			shreg <= 8'd0;
			chan_lat <= '0;
			sda_bit <= 1'b1;
			ack_fail <= 1'b0;
			scl <= 1'b1;
			sda_pull_low <= 1'b0;
			sample <= 8'd0;
			sample_valid <= 1'b0;
			nack_error <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			nack_error <= 1'b0;
			if (tick) begin
				quarter <= quarter + 2'd1;
				case (phase)
				PH_IDLE: begin
					if (quarter == 2'd3) begin
						phase <= PH_START;
						chan_lat <= channel;
						ack_fail <= 1'b0;
					end
				end
				PH_START: begin
					// sda falls halfway through the high scl
					if (quarter == 2'd1)
						sda_pull_low <= 1'b1;
					if (quarter == 2'd3) begin
						scl <= 1'b0;
						phase <= PH_BIT;
						byte_idx <= 2'd0;
						bit_cnt <= 4'd0;
						shreg <= {ADC_DEV_ADDR, 1'b0};
					end
				end
				PH_BIT: begin
					case (quarter)
					// data moves one quarter after scl falls
					2'd0: sda_pull_low <= tx_byte && (bit_cnt != 4'd8) && !shreg[7];
					2'd1: scl <= 1'b1;
					2'd2: sda_bit <= sda_sync[1];
					default: begin
						scl <= 1'b0;
						if (bit_cnt != 4'd8) begin
							bit_cnt <= bit_cnt + 4'd1;
							shreg <= {shreg[6:0], sda_bit};
						end else begin
							bit_cnt <= 4'd0;
							if (tx_byte && sda_bit) begin
								// slave did not answer, give up the transfer
								ack_fail <= 1'b1;
								phase <= PH_STOP;
							end else begin
								case (byte_idx)
								2'd0: begin
									byte_idx <= 2'd1;
									shreg <= {{(8 - CHAN_W){1'b0}}, chan_lat};
								end
								2'd1: phase <= PH_RSTART;
								2'd2: byte_idx <= 2'd3;
								default: phase <= PH_STOP;
								endcase
							end
						end
					end
					endcase
				end
				PH_RSTART: begin
					case (quarter)
					2'd0: sda_pull_low <= 1'b0;
					2'd1: scl <= 1'b1;
					2'd2: sda_pull_low <= 1'b1;
					default: begin
						scl <= 1'b0;
						phase <= PH_BIT;
						byte_idx <= 2'd2;
						shreg <= {ADC_DEV_ADDR, 1'b1};
					end
					endcase
				end
				PH_STOP: begin
					case (quarter)
					2'd0: sda_pull_low <= 1'b1;
					2'd1: scl <= 1'b1;
					2'd2: sda_pull_low <= 1'b0;
					default: begin
						phase <= PH_IDLE;
						sample_valid <= !ack_fail;
						nack_error <= ack_fail;
						if (!ack_fail)
							sample <= shreg;
					end
					endcase
				end
				default: phase <= PH_IDLE;
				endcase
			end
		end
	end

	// only start, repeated start and stop may move sda under a high scl
	sda_stable_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(scl && $past(scl) && $changed(sda_pull_low)) |->
		(phase == PH_START || phase == PH_RSTART || phase == PH_STOP));

	result_excl_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(sample_valid && nack_error));

endmodule

`default_nettype wire

// ==== src/panel_pkg.sv ====
/*
 * ADC panel shared definitions
 * timing constants, converter address, glyph codes and reader bus phases
 */
`default_nettype none

package panel_pkg;

	// I2C converter slave address (7 bit)
	localparam logic [6:0] ADC_DEV_ADDR = 7'h48;

	// about 100 kHz SCL at 25 MHz
	localparam int I2C_QUARTER = 63;
	localparam int QUARTER_W = $clog2(I2C_QUARTER);

	localparam int DEBOUNCE_CYCLES = 65536;
	localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES);

	localparam int SCAN_CYCLES = 1024;
	localparam int SCAN_W = $clog2(SCAN_CYCLES);

	localparam int CHAN_W = 2;

	// glyphs 0..15 are the hex digits themselves
	localparam int GLYPH_W = 5;
	localparam logic [GLYPH_W-1:0] GLYPH_BLANK = 5'd16;
	localparam logic [GLYPH_W-1:0] GLYPH_E = 5'd17;
	localparam logic [GLYPH_W-1:0] GLYPH_H = 5'd18;
	localparam logic [GLYPH_W-1:0] GLYPH_DASH = 5'd19;

	// I2C reader bit phases
	localparam logic [2:0] PH_IDLE = 3'd0;
	localparam logic [2:0] PH_START = 3'd1;
	localparam logic [2:0] PH_BIT = 3'd2;
	localparam logic [2:0] PH_RSTART = 3'd3;
	localparam logic [2:0] PH_STOP = 3'd4;

endpackage

`default_nettype wire
